// File: project.f
+incdir+verilog
verilog/aes_pkg.sv
verilog/wb_aes_regs.sv
verilog/block_fifo.sv
verilog/aes_sbox.sv
verilog/aes_enc_core.sv
verilog/aes_enc_top.sv
verification/tb_clock_gen.sv
verification/tb_aes_enc.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module tb_aes_enc
./obj_dir/Vtb_aes_enc

// File: verification/tb_aes_enc.sv
`timescale 1ns/1ns
`include "aes_defines.svh"

module tb_aes_enc;

    // Expanded AES-256 schedule, key 0 first
    typedef logic [0:`AES_NKEYS-1][127:0] key_sched_t;

    logic        clk;
    logic        resetn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [6:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    // Expected and observed ciphertexts, matched in order
    logic [127:0] exp_q[$];
    logic [127:0] act_q[$];
    logic [127:0] exp_word;
    logic [127:0] act_word;

    // Forward S-box built from the field inverse
    logic [7:0]   sbox_ref [256];
    longint       cycle_cnt;

    tb_clock_gen clock_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    aes_enc_top UUT (
        .clk      (clk),
        .resetn   (resetn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected)
            fail_run($sformatf("Error at %0t ns: %s expected %h, got %h",
                               $time, name, expected, actual));
    endtask

    // Carry-less product reduced by x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] b, input int n);
        return (b << n) | (b >> (8 - n));
    endfunction

    // Inverse as a^254, then the affine map
    function automatic logic [7:0] sbox_entry(input logic [7:0] a);
        logic [7:0] inv;
        inv = 8'h01;
        for (int i = 0; i < 254; i++)
            inv = gf_mul(inv, a);
        return inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3) ^ rotl8(inv, 4) ^ 8'h63;
    endfunction

    function automatic logic [31:0] sub_word(input logic [31:0] t);
        return {sbox_ref[t[31:24]], sbox_ref[t[23:16]], sbox_ref[t[15:8]], sbox_ref[t[7:0]]};
    endfunction

    // FIPS-197 key expansion, Nk = 8
    function automatic key_sched_t expand_key(input logic [255:0] key);
        logic [31:0] w [60];
        logic [31:0] temp;
        logic [7:0]  rcon;
        key_sched_t  ks;
        for (int i = 0; i < 8; i++)
            w[i] = key[255 - 32*i -: 32];
        rcon = 8'h01;
        for (int i = 8; i < 60; i++)
        begin
            temp = w[i-1];
            if (i % 8 == 0)
            begin
                // RotWord, SubWord, round constant
                temp = sub_word({temp[23:0], temp[31:24]}) ^ {rcon, 24'h000000};
                rcon = gf_mul(rcon, 8'h02);
            end
            else if (i % 8 == 4)
                temp = sub_word(temp);
            w[i] = w[i-8] ^ temp;
        end
        for (int k = 0; k < `AES_NKEYS; k++)
            ks[k] = {w[4*k], w[4*k+1], w[4*k+2], w[4*k+3]};
        return ks;
    endfunction

    function automatic logic [127:0] aes256_encrypt(input logic [255:0] key,
                                                    input logic [127:0] pt);
        key_sched_t   ks;
        logic [7:0]   s [16];
        logic [7:0]   t [16];
        logic [7:0]   a0;
        logic [7:0]   a1;
        logic [7:0]   a2;
        logic [7:0]   a3;
        logic [127:0] ct;
        ks = expand_key(key);
        // Byte i sits at column i/4, row i%4
        for (int i = 0; i < 16; i++)
            s[i] = pt[127 - 8*i -: 8] ^ ks[0][127 - 8*i -: 8];
        for (int rnd = 1; rnd <= `AES_ROUNDS; rnd++)
        begin
            // SubBytes then row r rotated left by r
            for (int c = 0; c < 4; c++)
            begin
                for (int r = 0; r < 4; r++)
                    t[4*c + r] = sbox_ref[s[4*((c + r) % 4) + r]];
            end
            for (int c = 0; c < 4; c++)
            begin
                a0 = t[4*c];
                a1 = t[4*c + 1];
                a2 = t[4*c + 2];
                a3 = t[4*c + 3];
                // Final round has no MixColumns
                if (rnd == `AES_ROUNDS)
                begin
                    s[4*c]     = a0;
                    s[4*c + 1] = a1;
                    s[4*c + 2] = a2;
                    s[4*c + 3] = a3;
                end
                else
                begin
                    s[4*c]     = gf_mul(a0, 8'h02) ^ gf_mul(a1, 8'h03) ^ a2 ^ a3;
                    s[4*c + 1] = a0 ^ gf_mul(a1, 8'h02) ^ gf_mul(a2, 8'h03) ^ a3;
                    s[4*c + 2] = a0 ^ a1 ^ gf_mul(a2, 8'h02) ^ gf_mul(a3, 8'h03);
                    s[4*c + 3] = gf_mul(a0, 8'h03) ^ a1 ^ a2 ^ gf_mul(a3, 8'h02);
                end
            end
            for (int i = 0; i < 16; i++)
                s[i] = s[i] ^ ks[rnd][127 - 8*i -: 8];
        end
        for (int i = 0; i < 16; i++)
            ct[127 - 8*i -: 8] = s[i];
        return ct;
    endfunction

    function automatic logic [127:0] rand_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Single Wishbone write, ack awaited on falling edges
    task automatic wb_write(input logic [6:0] adr, input logic [31:0] data);
        int   n;
        logic done;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        done = 1'b0;
        n = 0;
        while (!done && n < 20)
        begin
            @(negedge clk);
            n++;
            done = wb_ack;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!done)
            fail_run($sformatf("No ack within 20 cycles for write to word %0d", adr));
    endtask

    task automatic wb_read(input logic [6:0] adr, output logic [31:0] data);
        int   n;
        logic done;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        done = 1'b0;
        n = 0;
        data = '0;
        while (!done && n < 20)
        begin
            @(negedge clk);
            n++;
            done = wb_ack;
            // Read data only valid alongside ack
            if (done)
                data = wb_dat_r;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        if (!done)
            fail_run($sformatf("No ack within 20 cycles for read of word %0d", adr));
    endtask

    task automatic load_keys(input logic [255:0] key);
        key_sched_t ks;
        ks = expand_key(key);
        for (int k = 0; k < `AES_NKEYS; k++)
        begin
            for (int w = 0; w < 4; w++)
                wb_write(`REG_KEY + 7'(4*k + w), ks[k][127 - 32*w -: 32]);
        end
    endtask

    // Stage plaintext, most significant word first, then start
    task automatic start_block(input logic [127:0] pt);
        for (int w = 0; w < 4; w++)
            wb_write(`REG_DIN + 7'(w), pt[127 - 32*w -: 32]);
        wb_write(`REG_START, 32'h1);
    endtask

    task automatic wait_result();
        logic [31:0] word;
        logic        ready;
        longint      start;
        start = cycle_cnt;
        ready = 1'b0;
        while (!ready && cycle_cnt - start < 5000)
        begin
            wb_read(`REG_STATUS, word);
            ready = word[3];
        end
        if (!ready)
            fail_run("Timeout, result_valid not set within 5000 cycles");
    endtask

    // Word 11 last, which releases the core
    task automatic read_result();
        logic [31:0]  word;
        logic [127:0] ct;
        for (int w = 0; w < 4; w++)
        begin
            wb_read(`REG_DOUT + 7'(w), word);
            ct[127 - 32*w -: 32] = word;
        end
        act_q.push_back(ct);
    endtask

    task automatic check_status(input logic [31:0] expected);
        logic [31:0] word;
        wb_read(`REG_STATUS, word);
        check_value("status", {96'd0, expected}, {96'd0, word});
    endtask

    // Ciphertext comparison in start order
    always @(negedge clk)
    begin
        if (exp_q.size() > 0 && act_q.size() > 0)
        begin
            exp_word = exp_q.pop_front();
            act_word = act_q.pop_front();
            check_value("dout", exp_word, act_word);
        end
    end

    initial
    begin
        logic [255:0] key;
        logic [127:0] pt;
        logic [127:0] ct;
        int           n;
        cycle_cnt = 0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        // All byte lanes on
        wb_sel    = 4'hf;
        void'($urandom(32'heaaa));
        for (int i = 0; i < 256; i++)
            sbox_ref[i] = sbox_entry(8'(i));

        n = 0;
        while (resetn !== 1'b1 && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (resetn !== 1'b1)
            fail_run("Reset was never released");

        // Idle: only fifo_empty
        check_status(32'h2);

        // FIPS-197 C.3 vector
        key = 256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
        pt  = 128'h00112233445566778899aabbccddeeff;
        ct  = aes256_encrypt(key, pt);
        check_value("reference", 128'h8ea2b7ca516745bfeafc49904b496089, ct);
        load_keys(key);
        exp_q.push_back(ct);
        start_block(pt);
        wait_result();
        read_result();

        // Random key, one block at a time
        key = {rand_block(), rand_block()};
        load_keys(key);
        for (int i = 0; i < 8; i++)
        begin
            pt = rand_block();
            exp_q.push_back(aes256_encrypt(key, pt));
            start_block(pt);
            wait_result();
            read_result();
        end

        // Four back to back, then drained
        for (int i = 0; i < 4; i++)
        begin
            pt = rand_block();
            exp_q.push_back(aes256_encrypt(key, pt));
            start_block(pt);
        end
        for (int i = 0; i < 4; i++)
        begin
            wait_result();
            read_result();
        end

        // Hold one result, then fill the queue
        pt = rand_block();
        exp_q.push_back(aes256_encrypt(key, pt));
        start_block(pt);
        wait_result();
        for (int i = 0; i < 4; i++)
        begin
            pt = rand_block();
            exp_q.push_back(aes256_encrypt(key, pt));
            start_block(pt);
        end
        // result_valid and fifo_full
        check_status(32'h9);
        // Fifth start lost
        start_block(rand_block());
        check_status(32'h9);
        for (int i = 0; i < 5; i++)
        begin
            wait_result();
            read_result();
        end
        check_status(32'h2);

        n = 0;
        while ((exp_q.size() != 0 || act_q.size() != 0) && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0 || act_q.size() != 0)
            fail_run("Ciphertext count does not match the number of started blocks");
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen
(
    output logic clk,
    output logic resetn
);

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset low for four rising edges, released on a falling edge
    initial
    begin
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

// File: verilog/aes_enc_top.sv
`timescale 1ns/1ns

module aes_enc_top
    import aes_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [6:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  wb_sel,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    // Register block to queue
    logic         push;
    aes_state_u   push_data;
    logic         full;
    logic         empty;

    // Queue to core
    logic         pop;
    aes_state_u   pop_data;

    // Core to register block
    logic [3:0]   key_addr;
    logic [127:0] round_key;
    logic         result_we;
    aes_state_u   result;
    logic         busy;
    logic         result_valid;

    wb_aes_regs u_regs (
        .clk          (clk),
        .resetn       (resetn),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .full         (full),
        .empty        (empty),
        .key_addr     (key_addr),
        .result_we    (result_we),
        .result       (result),
        .busy         (busy),
        .push         (push),
        .push_data    (push_data),
        .round_key    (round_key),
        .result_valid (result_valid)
    );

    block_fifo u_fifo (
        .clk       (clk),
        .resetn    (resetn),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    aes_enc_core u_core (
        .clk          (clk),
        .resetn       (resetn),
        .empty        (empty),
        .pop_data     (pop_data),
        .round_key    (round_key),
        .result_valid (result_valid),
        .pop          (pop),
        .key_addr     (key_addr),
        .result_we    (result_we),
        .result       (result),
        .busy         (busy)
    );

endmodule

// File: verilog/aes_enc_core.sv
`timescale 1ns/1ns
`include "aes_defines.svh"

module aes_enc_core
    import aes_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         empty,
    input  aes_state_u   pop_data,
    input  logic [127:0] round_key,
    input  logic         result_valid,
    output logic         pop,
    output logic [3:0]   key_addr,
    output logic         result_we,
    output aes_state_u   result,
    output logic         busy
);

    // FSM encoding
    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_LOAD      = 3'd1;
    localparam logic [2:0] ST_ADD_KEY   = 3'd2;
    localparam logic [2:0] ST_SUB_BYTES = 3'd3;
    localparam logic [2:0] ST_SUB_WAIT  = 3'd4;
    localparam logic [2:0] ST_SHIFT     = 3'd5;
    localparam logic [2:0] ST_MIX       = 3'd6;
    localparam logic [2:0] ST_FINISH    = 3'd7;

    logic [2:0] fsm_q;
    // Round 0 is the initial AddRoundKey
    logic [3:0] round_q;
    // Byte being fed to the S-box
    logic [3:0] byte_cnt;
    // S-box output valid next cycle, and where it goes
    logic       issue_q;
    logic [3:0] issue_idx;

    aes_state_u   state_q;
    aes_state_u   sub_buf;
    aes_state_u   shifted;
    aes_state_u   mixed;
    // Round key held for the whole round
    logic [127:0] rk_q;

    logic [7:0] sbox_addr;
    logic [7:0] sbox_data;

    aes_sbox u_sbox (
        .clk  (clk),
        .addr (sbox_addr),
        .data (sbox_data)
    );

    // Take a block only when the last result has been read
    assign pop       = (fsm_q == ST_IDLE) && !empty && !result_valid;
    assign busy      = fsm_q != ST_IDLE;
    assign result_we = fsm_q == ST_FINISH;
    assign result    = state_q;
    assign key_addr  = round_q;

    assign sbox_addr = state_q.bytes[byte_cnt];

    // ShiftRows, row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted.bytes[4*c + r] = sub_buf.bytes[4*((c + r) % 4) + r];
            end
        end
    end

    // MixColumns, column 0 in the top word
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mixed.flat[(3 - c) * 32 +: 32] = mix_column(state_q.flat[(3 - c) * 32 +: 32]);
        end
    end

    // Control path
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            fsm_q    <= ST_IDLE;
            round_q  <= '0;
            byte_cnt <= '0;
            issue_q  <= 1'b0;
        end
        else
        begin
            issue_q <= fsm_q == ST_SUB_BYTES;
            case (fsm_q)
                ST_IDLE:
                begin
                    if (pop)
                    begin
                        round_q <= '0;
                        fsm_q   <= ST_LOAD;
                    end
                end
                ST_LOAD:
                begin
                    byte_cnt <= '0;
                    // First pass only whitens with key 0
                    fsm_q    <= (round_q == 4'd0) ? ST_ADD_KEY : ST_SUB_BYTES;
                end
                ST_SUB_BYTES:
                begin
                    byte_cnt <= byte_cnt + 4'd1;
                    if (byte_cnt == 4'd15)
                        fsm_q <= ST_SUB_WAIT;
                end
                ST_SUB_WAIT:
                    fsm_q <= ST_SHIFT;
                ST_SHIFT:
                begin
                    // Last round skips MixColumns
                    if (round_q == `AES_ROUNDS)
                        fsm_q <= ST_ADD_KEY;
                    else
                        fsm_q <= ST_MIX;
                end
                ST_MIX:
                    fsm_q <= ST_ADD_KEY;
                ST_ADD_KEY:
                begin
                    if (round_q == `AES_ROUNDS)
                        fsm_q <= ST_FINISH;
                    else
                    begin
                        round_q <= round_q + 4'd1;
                        fsm_q   <= ST_LOAD;
                    end
                end
                ST_FINISH:
                    fsm_q <= ST_IDLE;
                default:
                    fsm_q <= ST_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk)
    begin
        issue_idx <= byte_cnt;
        // Collect the S-box byte issued last cycle
        if (issue_q)
            sub_buf.bytes[issue_idx] <= sbox_data;
        case (fsm_q)
            ST_IDLE:
            begin
                if (pop)
                    state_q <= pop_data;
            end
            // Registers the key store output, breaks the long read path
            ST_LOAD:
                rk_q <= round_key;
            ST_SHIFT:
                state_q <= shifted;
            ST_MIX:
                state_q <= mixed;
            ST_ADD_KEY:
                state_q.flat <= state_q.flat ^ rk_q;
            default:
                ;
        endcase
    end

    // Key store only has AES_NKEYS entries
    a_key_addr_range: assert property (
        @(posedge clk) disable iff (!resetn) key_addr < `AES_NKEYS
    );

endmodule

// File: verilog/aes_sbox.sv
`timescale 1ns/1ns

module aes_sbox
(
    input  logic       clk,
    input  logic [7:0] addr,
    output logic [7:0] data
);

    // Forward S-box, entry 0 in the top byte
    // One 128-bit row per high nibble of the address
    localparam logic [0:255][7:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // Registered lookup, data follows addr by one cycle
    always_ff @(posedge clk)
    begin
        data <= SBOX[addr];
    end

endmodule

// File: verilog/block_fifo.sv
`timescale 1ns/1ns
`include "aes_defines.svh"

module block_fifo
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       push,
    input  aes_state_u push_data,
    input  logic       pop,
    output aes_state_u pop_data,
    output logic       full,
    output logic       empty
);

    localparam int DEPTH = 1 << `FIFO_DEPTH_LOG2;

    aes_state_u mem [DEPTH];

    // Extra top bit tells full from empty
    logic [`FIFO_DEPTH_LOG2:0] wr_ptr;
    logic [`FIFO_DEPTH_LOG2:0] rd_ptr;

    logic do_push;
    logic do_pop;

    assign empty = wr_ptr == rd_ptr;
    // Same slot, one lap apart
    assign full  = (wr_ptr[`FIFO_DEPTH_LOG2] != rd_ptr[`FIFO_DEPTH_LOG2])
                && (wr_ptr[`FIFO_DEPTH_LOG2-1:0] == rd_ptr[`FIFO_DEPTH_LOG2-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head entry visible without a pop
    assign pop_data = mem[rd_ptr[`FIFO_DEPTH_LOG2-1:0]];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr[`FIFO_DEPTH_LOG2-1:0]] <= push_data;
    end

    // Core only pops a block that is present
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!resetn) pop |-> !empty
    );

endmodule

// File: verilog/wb_aes_regs.sv
`timescale 1ns/1ns
`include "aes_defines.svh"

module wb_aes_regs
    import aes_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  logic [6:0]   wb_adr,
    input  logic [31:0]  wb_dat_w,
    input  logic [3:0]   wb_sel,
    output logic [31:0]  wb_dat_r,
    output logic         wb_ack,
    input  logic         full,
    input  logic         empty,
    input  logic [3:0]   key_addr,
    input  logic         result_we,
    input  aes_state_u   result,
    input  logic         busy,
    output logic         push,
    output aes_state_u   push_data,
    output logic [127:0] round_key,
    output logic         result_valid
);

    // Bus request qualifiers
    logic req;
    logic wr;
    logic rd;

    // Offsets relative to each register window
    logic [6:0] din_off;
    logic [6:0] dout_off;
    logic [6:0] key_off;

    // Window hits
    logic sel_din;
    logic sel_start;
    logic sel_dout;
    logic sel_status;
    logic sel_key;

    // Staging words, key store, result
    logic [31:0]  din [4];
    logic [127:0] key_mem [`AES_NKEYS];
    aes_state_u   result_q;

    aes_status_s  status;
    logic [31:0]  rd_word;

    // New access only when no ack is pending, so each strobe acks once
    assign req = wb_cyc && wb_stb && !wb_ack;
    // Whole-word accesses only
    assign wr  = req && wb_we;
    assign rd  = req && !wb_we;

    // Unsigned offsets wrap high below a window's base
    assign din_off  = wb_adr - `REG_DIN;
    assign dout_off = wb_adr - `REG_DOUT;
    assign key_off  = wb_adr - `REG_KEY;

    assign sel_din    = din_off < 7'd4;
    assign sel_start  = wb_adr == `REG_START;
    assign sel_dout   = dout_off < 7'd4;
    assign sel_status = wb_adr == `REG_STATUS;
    assign sel_key    = key_off < 4 * `AES_NKEYS;

    // Start strobe, dropped while the queue is full
    assign push = wr && sel_start && !full;
    // Word 0 carries the most significant bytes
    assign push_data.flat = {din[0], din[1], din[2], din[3]};

    // Key store read port for the core
    assign round_key = key_mem[key_addr];

    assign status.result_valid = result_valid;
    assign status.core_busy    = busy;
    assign status.fifo_empty   = empty;
    assign status.fifo_full    = full;

    // Read mux, unmapped words give zero
    always_comb
    begin
        rd_word = '0;
        if (sel_din)
            rd_word = din[din_off[1:0]];
        else if (sel_dout)
            rd_word = result_q.flat[(3 - dout_off[1:0]) * 32 +: 32];
        else if (sel_status)
            rd_word = {28'd0, status};
        else if (sel_key)
            rd_word = key_mem[key_off[5:2]][(3 - key_off[1:0]) * 32 +: 32];
    end

    // Ack, read data and result handshake
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wb_ack       <= 1'b0;
            wb_dat_r     <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            wb_ack   <= req;
            wb_dat_r <= rd ? rd_word : '0;
            // Last ciphertext word read frees the core
            if (rd && sel_dout && dout_off[1:0] == 2'd3)
                result_valid <= 1'b0;
            if (result_we)
                result_valid <= 1'b1;
        end
    end

    // Payload storage
    always_ff @(posedge clk)
    begin
        if (wr && sel_din)
            din[din_off[1:0]] <= wb_dat_w;
        if (wr && sel_key)
            key_mem[key_off[5:2]][(3 - key_off[1:0]) * 32 +: 32] <= wb_dat_w;
        if (result_we)
            result_q <= result;
    end

    // Core must wait for the host to drain the previous result
    a_no_result_overwrite: assert property (
        @(posedge clk) disable iff (!resetn) result_we |-> !result_valid
    );

endmodule

// File: verilog/aes_pkg.sv
package aes_pkg;

    // One AES block, as a flat word or as 16 bytes
    // Byte 0 is the most significant, index = 4*column + row
    typedef union packed {
        logic [127:0]      flat;
        logic [0:15][7:0]  bytes;
    } aes_state_u;

    // Low four bits of the status word, fifo_full in bit 0
    typedef struct packed {
        logic result_valid;
        logic core_busy;
        logic fifo_empty;
        logic fifo_full;
    } aes_status_s;

    // Multiply by x in GF(2^8), reduction polynomial 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] b);
        xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // MixColumns on one column, row 0 in the top byte
    function automatic logic [31:0] mix_column(input logic [31:0] col);
        logic [7:0] s0;
        logic [7:0] s1;
        logic [7:0] s2;
        logic [7:0] s3;
        s0 = col[31:24];
        s1 = col[23:16];
        s2 = col[15:8];
        s3 = col[7:0];
        // Rows of the circulant matrix 2 3 1 1
        mix_column[31:24] = xtime(s0) ^ xtime(s1) ^ s1 ^ s2 ^ s3;
        mix_column[23:16] = s0 ^ xtime(s1) ^ xtime(s2) ^ s2 ^ s3;
        mix_column[15:8]  = s0 ^ s1 ^ xtime(s2) ^ xtime(s3) ^ s3;
        mix_column[7:0]   = xtime(s0) ^ s0 ^ s1 ^ s2 ^ xtime(s3);
    endfunction

endpackage

// File: verilog/aes_defines.svh
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// AES-256 round count
`define AES_ROUNDS 14

// Round keys in an expanded AES-256 schedule
`define AES_NKEYS 15

// Block queue holds 1 << FIFO_DEPTH_LOG2 entries
`define FIFO_DEPTH_LOG2 2

// Wishbone word offsets
// Plaintext staging, words 0 to 3
`define REG_DIN 7'd0
// Push staged block into queue
`define REG_START 7'd4
// Ciphertext, words 8 to 11, reading word 11 releases the result
`define REG_DOUT 7'd8
// Status bits, read only
`define REG_STATUS 7'd12
// Round key k at word REG_KEY + 4k
`define REG_KEY 7'd64

`endif
